/* rtl/gambit_defs.svh */
// queue size, retire width, sequence number, tag and index width macros
`ifndef GAMBIT_DEFS_SVH
`define GAMBIT_DEFS_SVH

// ====================
// queue geometry
// ====================

// number of slots in the instruction queue
`define IQ_ENTRIES 8
// index width, enough to address IQ_ENTRIES slots
`define QBITS_W 3
// most entries that can retire in one cycle
`define QSLOTS 2

// ====================
// field widths
// ====================

// sequence number width
// top quarter of the range starts at 48, one quarter is 16
`define SN_W 6
// instruction tag width
`define TAG_W 4

`endif

/* rtl/gambit_pkg.sv */
// sequence number and tag types, enqueue, completion and retire structs, slot state enum
`default_nettype none

`include "gambit_defs.svh"

package gambit_pkg;

	// ====================
	// scalar types
	// ====================

	// sequence number held per slot
	typedef logic [`SN_W-1:0] sn_t;

	// instruction tag, unique among live entries
	typedef logic [`TAG_W-1:0] tag_t;

	// ====================
	// slot state
	// ====================

	// empty slots are free for the tail
	// waiting slots hold an instruction not yet finished
	// done slots may retire once every older slot is done
	typedef enum logic [1:0] {
		ST_EMPTY   = 2'd0,
		ST_WAITING = 2'd1,
		ST_DONE    = 2'd2
	} entry_state_e;

	// ====================
	// grouped port signals
	// ====================

	// one new instruction from the producer
	typedef struct packed {
		logic valid;
		tag_t tag;
	} enq_req_t;

	// finish notice, looked up by tag
	typedef struct packed {
		logic valid;
		tag_t tag;
	} cmpl_t;

	// one retire report, oldest report sits in index 0
	typedef struct packed {
		logic valid;
		tag_t tag;
		sn_t  sn;
	} ret_slot_t;

endpackage

`default_nettype wire

/* rtl/seqnum.sv */
// combinational largest live sequence number and renormalization amount finder
`timescale 1ns/1ps
`default_nettype none

`include "gambit_defs.svh"

module seqnum (
	input  gambit_pkg::entry_state_e slot_state [`IQ_ENTRIES],
	input  gambit_pkg::sn_t          slot_sn    [`IQ_ENTRIES],
	output gambit_pkg::sn_t          maxsn,
	output gambit_pkg::sn_t          tosub
);
	import gambit_pkg::*;

	// one quarter of the sequence number range
	localparam sn_t SN_QUARTER = {2'b01, {(`SN_W - 2){1'b0}}};

	// largest number among live slots, before any lowering
	sn_t  raw_max;
	// set while the maximum sits in the top quarter
	logic renorm;

	// ====================
	// maximum scan
	// ====================

	// empty slots hold stale numbers and are skipped
	// an empty queue gives zero, so the first instruction gets 1
	always_comb
	begin
		raw_max = '0;
		for (int n = 0; n < `IQ_ENTRIES; n++)
		begin
			if (slot_state[n] != ST_EMPTY && slot_sn[n] > raw_max)
				raw_max = slot_sn[n];
		end
	end

	// ====================
	// renormalization
	// ====================

	// top two bits both one means 48 or more
	assign renorm = &raw_max[`SN_W-1 -: 2];

	// every live number drops by a quarter in the same edge
	assign tosub = renorm ? SN_QUARTER : '0;

	// hand out the lowered maximum so the new entry lines up
	// with the lowered live numbers
	// live numbers span at most IQ_ENTRIES values, so nothing goes below zero
	assign maxsn = raw_max - tosub;

endmodule

`default_nettype wire

/* rtl/iq_entries.sv */
// queue slot storage with tail pointer, enqueue, completion, retire clear and renormalization
`timescale 1ns/1ps
`default_nettype none

`include "gambit_defs.svh"

module iq_entries (
	input  logic                     clk,
	input  logic                     rst_n,
	input  gambit_pkg::enq_req_t     enq,
	input  gambit_pkg::cmpl_t        cmpl,
	input  gambit_pkg::sn_t          maxsn,
	input  gambit_pkg::sn_t          tosub,
	input  logic [`IQ_ENTRIES-1:0]   clr_mask,
	output gambit_pkg::entry_state_e slot_state [`IQ_ENTRIES],
	output gambit_pkg::tag_t         slot_tag   [`IQ_ENTRIES],
	output gambit_pkg::sn_t          slot_sn    [`IQ_ENTRIES]
);
	import gambit_pkg::*;

	// next slot to be written
	logic [`QBITS_W-1:0]    tail;
	logic [`QBITS_W-1:0]    tail_nxt;
	// number given to the incoming instruction
	sn_t                    new_sn;
	// one-hot slot select for the enqueue write
	logic [`IQ_ENTRIES-1:0] wr_sel;
	// slots matched by the completion tag
	logic [`IQ_ENTRIES-1:0] cmpl_hit;

	// ====================
	// tail and numbering
	// ====================

	// maxsn is already lowered when renormalizing,
	// so plus one stays consecutive with the lowered live numbers
	assign new_sn = maxsn + sn_t'(1);

	// circular tail, wraps after the last slot
	always_comb
	begin
		if (int'(tail) == `IQ_ENTRIES - 1)
			tail_nxt = '0;
		else
			tail_nxt = tail + 1'b1;
	end

	// ====================
	// per-slot decode
	// ====================

	// the producer only enqueues with credit left, so the tail slot is free
	// a tag that is not waiting anywhere gets no hit and is ignored
	always_comb
	begin
		for (int i = 0; i < `IQ_ENTRIES; i++)
		begin
			wr_sel[i] = enq.valid && (int'(tail) == i);
			cmpl_hit[i] = cmpl.valid
				&& (slot_state[i] == ST_WAITING)
				&& (slot_tag[i] == cmpl.tag);
		end
	end

	// ====================
	// state and tail registers
	// ====================

	// slot FSM: empty -> waiting -> done -> empty
	// a slot being written is empty, so it never sees a clear or a hit
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			tail <= '0;
			for (int i = 0; i < `IQ_ENTRIES; i++)
				slot_state[i] <= ST_EMPTY;
		end
		else
		begin
			if (enq.valid)
				tail <= tail_nxt;
			for (int i = 0; i < `IQ_ENTRIES; i++)
			begin
				if (wr_sel[i])
					slot_state[i] <= ST_WAITING;
				else if (clr_mask[i])
					// retired this cycle by retire_heads
					slot_state[i] <= ST_EMPTY;
				else if (cmpl_hit[i])
					slot_state[i] <= ST_DONE;
			end
		end
	end

	// ====================
	// tag and number storage
	// ====================

	// tosub is zero outside renormalization, so live numbers hold
	// retiring slots get lowered too, harmless since they go empty
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < `IQ_ENTRIES; i++)
		begin
			if (wr_sel[i])
			begin
				slot_tag[i] <= enq.tag;
				slot_sn[i]  <= new_sn;
			end
			else if (slot_state[i] != ST_EMPTY)
			begin
				slot_sn[i] <= slot_sn[i] - tosub;
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/retire_heads.sv */
// head pointer, in-order retire selection, retire reports, clear mask and credit count
`timescale 1ns/1ps
`default_nettype none

`include "gambit_defs.svh"

module retire_heads (
	input  logic                           clk,
	input  logic                           rst_n,
	input  gambit_pkg::entry_state_e       slot_state [`IQ_ENTRIES],
	input  gambit_pkg::tag_t               slot_tag   [`IQ_ENTRIES],
	input  gambit_pkg::sn_t                slot_sn    [`IQ_ENTRIES],
	output gambit_pkg::ret_slot_t          ret        [`QSLOTS],
	output logic [`IQ_ENTRIES-1:0]         clr_mask,
	output logic [$clog2(`QSLOTS+1)-1:0]   credit_ret
);
	import gambit_pkg::*;

	// oldest live slot
	logic [`QBITS_W-1:0] head;
	logic [`QBITS_W-1:0] head_nxt;
	// slot looked at by each retire lane
	logic [`QBITS_W-1:0] pos [`QSLOTS];
	// cleared at the first lane that is not done
	logic                run;

	// slot a given distance past base, wrapping at the queue end
	function automatic logic [`QBITS_W-1:0] wrap_add(
		input logic [`QBITS_W-1:0] base,
		input int                  offs
	);
		int sum;
		sum = int'(base) + offs;
		if (sum >= `IQ_ENTRIES)
			sum = sum - `IQ_ENTRIES;
		return sum[`QBITS_W-1:0];
	endfunction

	// ====================
	// lane positions
	// ====================

	always_comb
	begin
		for (int k = 0; k < `QSLOTS; k++)
			pos[k] = wrap_add(head, k);
	end

	// ====================
	// in-order walk
	// ====================

	// lane 0 is the head, each later lane needs all earlier lanes done
	// an empty head slot also stops the walk
	always_comb
	begin
		run = 1'b1;
		clr_mask = '0;
		credit_ret = '0;
		for (int k = 0; k < `QSLOTS; k++)
		begin
			ret[k] = '0;
			if (run && slot_state[pos[k]] == ST_DONE)
			begin
				ret[k].valid = 1'b1;
				ret[k].tag = slot_tag[pos[k]];
				ret[k].sn = slot_sn[pos[k]];
				clr_mask[pos[k]] = 1'b1;
				// one credit per report
				credit_ret = credit_ret + 1'b1;
			end
			else
			begin
				run = 1'b0;
			end
		end
	end

	// ====================
	// head register
	// ====================

	// move past every slot retired this cycle
	assign head_nxt = wrap_add(head, int'(credit_ret));

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			head <= '0;
		else
			head <= head_nxt;
	end

endmodule

`default_nettype wire

/* rtl/sn_top.sv */
// top level joining slot storage, maximum finder and retire selection
`timescale 1ns/1ps
`default_nettype none

`include "gambit_defs.svh"

module sn_top (
	input  logic                         clk,
	input  logic                         rst_n,
	input  gambit_pkg::enq_req_t         enq,
	input  gambit_pkg::cmpl_t            cmpl,
	output gambit_pkg::ret_slot_t        ret        [`QSLOTS],
	output logic [$clog2(`QSLOTS+1)-1:0] credit_ret
);
	import gambit_pkg::*;

	// ====================
	// slot contents
	// ====================

	entry_state_e           slot_state [`IQ_ENTRIES];
	tag_t                   slot_tag   [`IQ_ENTRIES];
	sn_t                    slot_sn    [`IQ_ENTRIES];

	// numbering feedback from seqnum
	sn_t                    maxsn;
	sn_t                    tosub;

	// slots retired this cycle
	logic [`IQ_ENTRIES-1:0] clr_mask;

	// storage, owns the tail
	iq_entries u_entries (
		.clk        (clk),
		.rst_n      (rst_n),
		.enq        (enq),
		.cmpl       (cmpl),
		.maxsn      (maxsn),
		.tosub      (tosub),
		.clr_mask   (clr_mask),
		.slot_state (slot_state),
		.slot_tag   (slot_tag),
		.slot_sn    (slot_sn)
	);

	// largest live number and the renormalization step
	seqnum u_seqnum (
		.slot_state (slot_state),
		.slot_sn    (slot_sn),
		.maxsn      (maxsn),
		.tosub      (tosub)
	);

	// retire in queue order, owns the head
	retire_heads u_retire (
		.clk        (clk),
		.rst_n      (rst_n),
		.slot_state (slot_state),
		.slot_tag   (slot_tag),
		.slot_sn    (slot_sn),
		.ret        (ret),
		.clr_mask   (clr_mask),
		.credit_ret (credit_ret)
	);

endmodule

`default_nettype wire

/* sim/sn_checker.sv */
// retire stream checker with per-cycle expected reports, lane and credit compares, test and total counts
`timescale 1ns/1ps
`default_nettype none

`include "gambit_defs.svh"

module sn_checker (
	input logic                         clk,
	input logic                         rst_n,
	input gambit_pkg::ret_slot_t        ret [`QSLOTS],
	input logic [$clog2(`QSLOTS+1)-1:0] credit_ret
);
	import gambit_pkg::*;

	// expected lanes of one cycle, lane 0 holds the oldest report
	ret_slot_t [`QSLOTS-1:0] exp_q [$];
	// cycle in which each queued entry is due
	int                      due_q [$];
	// rising edges seen so far
	int                      cyc = 0;

	int err_cnt = 0;
	int chk_cnt = 0;
	int test_err = 0;
	int test_chk = 0;
	int tests_run = 0;
	int tests_bad = 0;

	// reports for a step show up in the cycle after it is driven
	task automatic push_exp(input ret_slot_t [`QSLOTS-1:0] lanes);
		due_q.push_back(cyc + 1);
		exp_q.push_back(lanes);
	endtask

	function automatic int pending_count();
		return exp_q.size();
	endfunction

	task automatic flag(input string msg);
		$display("ERR @%0t: %s", $time, msg);
		err_cnt++;
		test_err++;
	endtask

	always @(posedge clk)
		cyc = cyc + 1;

	// ====================
	// retire sampling
	// ====================

	// ret comes from registered slot state, so mid-cycle is settled
	// a cycle with nothing due expects idle lanes and no credit
	always @(negedge clk)
	begin
		ret_slot_t [`QSLOTS-1:0] exp;
		int                      n_exp;
		exp = '0;
		n_exp = 0;
		if (due_q.size() != 0 && due_q[0] == cyc)
		begin
			due_q.delete(0);
			exp = exp_q.pop_front();
		end
		for (int k = 0; k < `QSLOTS; k++)
		begin
			if (exp[k].valid)
				n_exp++;
			if (ret[k].valid && !rst_n)
				flag($sformatf("lane %0d valid during reset", k));
			else if (ret[k].valid != exp[k].valid)
				flag($sformatf("lane %0d valid %0b, expected %0b",
					k, ret[k].valid, exp[k].valid));
			else if (ret[k].valid)
			begin
				chk_cnt++;
				test_chk++;
				if (ret[k].tag != exp[k].tag || ret[k].sn != exp[k].sn)
					flag($sformatf("lane %0d got tag %0h sn %0d, expected tag %0h sn %0d",
						k, ret[k].tag, ret[k].sn, exp[k].tag, exp[k].sn));
			end
		end
		// one credit per expected report
		if (int'(credit_ret) != n_exp)
			flag($sformatf("credit_ret %0d, expected %0d", credit_ret, n_exp));
	end

	// ====================
	// summaries
	// ====================

	task automatic close_test(input int id);
		tests_run++;
		if (test_err != 0)
			tests_bad++;
		$display("test %0d: %s, %0d reports checked, %0d errors",
			id, (test_err == 0) ? "ok" : "failed", test_chk, test_err);
		test_err = 0;
		test_chk = 0;
	endtask

	task automatic report_counts();
		$display("tests %0d, failed %0d, reports checked %0d, errors %0d",
			tests_run, tests_bad, chk_cnt, err_cnt);
	endtask

endmodule

`default_nettype wire

/* sim/tb_sn.sv */
// testbench top with clock, reset, trace reading, producer credit, stimulus driving and watchdog
`timescale 1ns/1ps
`default_nettype none

`include "gambit_defs.svh"

module tb_sn;
	import gambit_pkg::*;

	localparam int MAX_REC = 64;
	localparam int RST_CYC = 16;
	localparam int CREDITS = `IQ_ENTRIES;

	logic                         clk;
	logic                         rst_n;
	enq_req_t                     enq;
	cmpl_t                        cmpl;
	ret_slot_t                    ret [`QSLOTS];
	logic [$clog2(`QSLOTS+1)-1:0] credit_ret;

	// one record per line, see the column notes in the trace file
	logic [59:0] trace [MAX_REC];
	int          n_rec;
	// cycles the trace takes once repeats are expanded
	int          n_cyc;
	logic        loaded = 1'b0;

	// producer credit is CREDITS plus returned minus issued
	int credit_in = 0;
	int n_enq = 0;

	sn_top u_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.enq        (enq),
		.cmpl       (cmpl),
		.ret        (ret),
		.credit_ret (credit_ret)
	);

	sn_checker u_chk (
		.clk        (clk),
		.rst_n      (rst_n),
		.ret        (ret),
		.credit_ret (credit_ret)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// returned credits are picked up mid-cycle where credit_ret is settled
	always @(negedge clk)
	begin
		if (!rst_n)
			credit_in = 0;
		else
			credit_in = credit_in + int'(credit_ret);
	end

	function automatic int free_credits();
		return CREDITS + credit_in - n_enq;
	endfunction

	// inputs change 1 ns after the edge and are taken at the next edge
	task automatic drive_cycle(input logic ev, input tag_t et, input logic cv, input tag_t ct);
		@(posedge clk);
		#1;
		enq.valid = ev;
		enq.tag = et;
		cmpl.valid = cv;
		cmpl.tag = ct;
		if (ev)
			n_enq++;
	endtask

	// one trace lane field: valid in bit 12, tag in 11:8, sn in 7:0
	// tag and sn step with the repeat index
	function automatic ret_slot_t lane_exp(input logic [15:0] f, input int i);
		ret_slot_t r;
		r = '0;
		if (f[12])
		begin
			r.valid = 1'b1;
			r.tag = tag_t'(int'(f[11:8]) + i);
			r.sn = sn_t'(int'(f[7:0]) + i);
		end
		return r;
	endfunction

	// expected reports of one step, due in the cycle after it
	task automatic push_step(input logic [59:0] rec, input int i);
		ret_slot_t [`QSLOTS-1:0] lanes;
		lanes[0] = lane_exp(rec[31:16], i);
		lanes[1] = lane_exp(rec[15:0], i);
		if (lanes[0].valid || lanes[1].valid)
			u_chk.push_exp(lanes);
	endtask

	task automatic apply_step(input logic [59:0] rec, input int i);
		logic ev;
		logic cv;
		tag_t et;
		tag_t ct;
		ev = rec[44];
		cv = rec[36];
		et = tag_t'(int'(rec[43:40]) + i);
		ct = tag_t'(int'(rec[35:32]) + i);
		if (ev && free_credits() <= 0)
		begin
			// completion goes out now, the enqueue waits for a credit
			drive_cycle(1'b0, '0, cv, ct);
			push_step(rec, i);
			while (free_credits() <= 0)
				drive_cycle(1'b0, '0, 1'b0, '0);
			drive_cycle(1'b1, et, 1'b0, '0);
		end
		else
		begin
			drive_cycle(ev, et, cv, ct);
			push_step(rec, i);
		end
	endtask

	// idle until every expected report has been seen, so the queue is empty
	task automatic drain_test(input int id);
		drive_cycle(1'b0, '0, 1'b0, '0);
		while (u_chk.pending_count() != 0)
			drive_cycle(1'b0, '0, 1'b0, '0);
		u_chk.close_test(id);
	endtask

	// ====================
	// main sequence
	// ====================

	initial
	begin
		int cur_test;
		int rec_test;
		enq = '0;
		cmpl = '0;
		rst_n = 1'b0;
		// records past the end of the file keep a zero repeat count
		for (int r = 0; r < MAX_REC; r++)
			trace[r] = 60'(r);
		$readmemh("sim/sn_trace.txt", trace);
		// a zero repeat count ends the trace
		n_rec = 0;
		n_cyc = 0;
		while (n_rec < MAX_REC && trace[n_rec][59:52] != 8'h00)
		begin
			n_cyc += int'(trace[n_rec][59:52]);
			n_rec++;
		end
		loaded = 1'b1;
		repeat (RST_CYC) @(posedge clk);
		#1;
		rst_n = 1'b1;
		cur_test = int'(trace[0][51:48]);
		for (int r = 0; r < n_rec; r++)
		begin
			rec_test = int'(trace[r][51:48]);
			if (rec_test != cur_test)
			begin
				drain_test(cur_test);
				cur_test = rec_test;
			end
			for (int i = 0; i < int'(trace[r][59:52]); i++)
				apply_step(trace[r], i);
		end
		drain_test(cur_test);
		// a few quiet cycles catch stray reports
		repeat (4) drive_cycle(1'b0, '0, 1'b0, '0);
		u_chk.report_counts();
		if (n_rec != 0 && u_chk.err_cnt == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	// watchdog sized from the expanded trace length
	initial
	begin
		wait (loaded);
		repeat (RST_CYC + n_cyc + 50) @(posedge clk);
		$display("timeout: the trace did not finish within %0d cycles", RST_CYC + n_cyc + 50);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

/* sim/sn_trace.txt */
// cnt_test_enq(valid,tag)_cmpl(valid,tag)_ret0(valid,tag,sn)_ret1(valid,tag,sn), all hex
// cnt above one repeats the record with every tag and sn stepped by one
04_1_00_00_0000_0000
01_1_11_00_0000_0000
01_1_00_11_1101_0000
04_2_12_00_0000_0000
04_2_00_12_1201_0000
03_3_16_00_0000_0000
01_3_00_18_0000_0000
01_3_00_17_0000_0000
01_3_00_16_1601_1702
01_3_00_00_1803_0000
08_4_10_00_0000_0000
01_4_18_10_1001_0000
08_4_00_11_1102_0000
02_5_10_00_0000_0000
2E_5_12_10_1001_0000
06_5_10_1E_1E1F_0000
02_5_00_14_1425_0000
01_6_13_00_0000_0000
01_6_00_19_0000_0000
01_6_00_13_1301_0000

/* all.f */
+incdir+rtl
rtl/gambit_pkg.sv
rtl/seqnum.sv
rtl/iq_entries.sv
rtl/retire_heads.sv
rtl/sn_top.sv
sim/sn_checker.sv
sim/tb_sn.sv

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module tb_sn -o tb_sn_sim
./obj_dir/tb_sn_sim | tee sim.log

if grep -qF "=== FAIL ===" sim.log; then
	exit 1
fi
exit 0
